// File: bno085_controller.sv
`timescale 1ns/1ps
`default_nettype none

module bno085_controller #(
    parameter int unsigned RESET_CYCLES       = 300000,
    parameter int unsigned WAKE_CYCLES        = 450,
    parameter int unsigned INT_TIMEOUT_CYCLES = 150000,
    parameter int unsigned GAP_CYCLES         = 30000
) (
    input  logic             clk,
    input  logic             rst_n,
    output logic             spi_start,
    output bno_pkg::byte_t   spi_tx_data,
    input  logic             spi_busy,
    input  logic             spi_rx_valid,
    input  bno_pkg::byte_t   spi_rx_data,
    output logic             cs_n,
    output logic             ps0_wake,
    input  logic             int_n,
    output logic             quat_valid,
    output bno_pkg::sample_t quat_w,
    output bno_pkg::sample_t quat_x,
    output bno_pkg::sample_t quat_y,
    output bno_pkg::sample_t quat_z,
    output logic             gyro_valid,
    output bno_pkg::sample_t gyro_x,
    output bno_pkg::sample_t gyro_y,
    output bno_pkg::sample_t gyro_z,
    output logic             initialized,
    output logic             error
);
    import bno_pkg::*;

    logic       delay_run;
    delay_sel_t delay_sel;
    logic       delay_done;
    step_t      cmd_step;
    logic       cmd_clear;
    logic       cmd_advance;
    byte_t      cmd_byte;
    logic       cmd_last;
    logic       pkt_clear;
    logic       hdr_done;
    logic       hdr_ok;
    logic       pkt_last;

    bno_sequencer u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .int_n        (int_n),
        .spi_busy     (spi_busy),
        .spi_rx_valid (spi_rx_valid),
        .spi_start    (spi_start),
        .spi_tx_data  (spi_tx_data),
        .cs_n         (cs_n),
        .ps0_wake     (ps0_wake),
        .initialized  (initialized),
        .error        (error),
        .delay_run    (delay_run),
        .delay_sel    (delay_sel),
        .delay_done   (delay_done),
        .cmd_step     (cmd_step),
        .cmd_clear    (cmd_clear),
        .cmd_advance  (cmd_advance),
        .cmd_byte     (cmd_byte),
        .cmd_last     (cmd_last),
        .pkt_clear    (pkt_clear),
        .hdr_done     (hdr_done),
        .hdr_ok       (hdr_ok),
        .pkt_last     (pkt_last)
    );

    bno_delay_timer #(
        .RESET_CYCLES       (RESET_CYCLES),
        .WAKE_CYCLES        (WAKE_CYCLES),
        .INT_TIMEOUT_CYCLES (INT_TIMEOUT_CYCLES),
        .GAP_CYCLES         (GAP_CYCLES)
    ) u_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .delay_run  (delay_run),
        .delay_sel  (delay_sel),
        .delay_done (delay_done)
    );

    shtp_cmd_rom u_rom (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_step    (cmd_step),
        .cmd_clear   (cmd_clear),
        .cmd_advance (cmd_advance),
        .cmd_byte    (cmd_byte),
        .cmd_last    (cmd_last)
    );

    shtp_packet_parser u_parser (
        .clk          (clk),
        .rst_n        (rst_n),
        .pkt_clear    (pkt_clear),
        .spi_rx_valid (spi_rx_valid),
        .spi_rx_data  (spi_rx_data),
        .hdr_done     (hdr_done),
        .hdr_ok       (hdr_ok),
        .pkt_last     (pkt_last),
        .quat_valid   (quat_valid),
        .quat_w       (quat_w),
        .quat_x       (quat_x),
        .quat_y       (quat_y),
        .quat_z       (quat_z),
        .gyro_valid   (gyro_valid),
        .gyro_x       (gyro_x),
        .gyro_y       (gyro_y),
        .gyro_z       (gyro_z)
    );

endmodule

`default_nettype wire

// File: bno085_sva.sv
`timescale 1ns/1ps
`default_nettype none

module bno085_sva (
    input logic clk,
    input logic rst_n,
    input logic spi_start,
    input logic spi_busy,
    input logic cs_n,
    input logic quat_valid,
    input logic gyro_valid,
    input logic error
);
    int fail_count = 0;  // Failed assertions so far

    // One byte outstanding at a time
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        spi_start |-> !spi_busy)
    else begin
        fail_count++;
        $error("spi_start issued while spi_busy was high");
    end

    a_start_cs: assert property (@(posedge clk) disable iff (!rst_n)
        spi_start |-> !cs_n)
    else begin
        fail_count++;
        $error("spi_start issued with cs_n high");
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (quat_valid || gyro_valid) |=> !(quat_valid || gyro_valid))
    else begin
        fail_count++;
        $error("Valid pulse longer than one cycle");
    end

    // Sticky flag
    a_error_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        !$fell(error))
    else begin
        fail_count++;
        $error("error fell without a reset");
    end

endmodule

`default_nettype wire

// File: bno_delay_timer.sv
`timescale 1ns/1ps
`default_nettype none

module bno_delay_timer #(
    parameter int unsigned RESET_CYCLES       = 300000,
    parameter int unsigned WAKE_CYCLES        = 450,
    parameter int unsigned INT_TIMEOUT_CYCLES = 150000,
    parameter int unsigned GAP_CYCLES         = 30000
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                delay_run,
    input  bno_pkg::delay_sel_t delay_sel,
    output logic                delay_done
);
    import bno_pkg::*;

    logic [TIMER_W-1:0] count;
    logic [TIMER_W-1:0] limit;

    always_comb begin
        case (delay_sel)
            DLY_POWER_UP:    limit = TIMER_W'(RESET_CYCLES);
            DLY_WAKE:        limit = TIMER_W'(WAKE_CYCLES);
            DLY_INT_TIMEOUT: limit = TIMER_W'(INT_TIMEOUT_CYCLES);
            default:         limit = TIMER_W'(GAP_CYCLES);
        endcase
    end

    // Held at zero whenever the sequencer is not timing anything
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!delay_run) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign delay_done = count >= limit;

endmodule

`default_nettype wire

// File: bno_pkg.sv
`default_nettype none

package bno_pkg;

    typedef logic [7:0]         byte_t;
    typedef logic [14:0]        pkt_len_t;   // Continuation bit stripped
    typedef logic signed [15:0] sample_t;
    typedef logic [1:0]         step_t;
    typedef logic [4:0]         cmd_idx_t;

    localparam int TIMER_W = 19;

    // SHTP channels
    localparam byte_t CHANNEL_CONTROL = 8'h02;
    localparam byte_t CHANNEL_REPORTS = 8'h03;
    localparam byte_t CHANNEL_GYRO_RV = 8'h05;

    // Report IDs
    localparam byte_t REPORT_ID_ROTATION_VECTOR = 8'h05;
    localparam byte_t REPORT_ID_GYROSCOPE       = 8'h02;
    localparam byte_t REPORT_ID_PRODUCT_ID_REQ  = 8'hF9;
    localparam byte_t REPORT_ID_SET_FEATURE     = 8'hFD;

    localparam logic [31:0] REPORT_INTERVAL_US = 32'd20000;  // 50 Hz

    localparam int SHTP_HDR_BYTES = 4;

    typedef enum logic [3:0] {
        ST_POWER_UP,
        ST_WAKE,
        ST_WAIT_INT,
        ST_CS_SETUP,
        ST_SEND_CMD,
        ST_GAP,
        ST_IDLE,
        ST_READ_HDR,
        ST_READ_PAYLOAD
    } seq_state_t;

    typedef enum logic [1:0] {
        DLY_POWER_UP,
        DLY_WAKE,
        DLY_INT_TIMEOUT,
        DLY_GAP
    } delay_sel_t;

endpackage

`default_nettype wire

// File: bno_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module bno_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                int_n,
    input  logic                spi_busy,
    input  logic                spi_rx_valid,
    output logic                spi_start,
    output bno_pkg::byte_t      spi_tx_data,
    output logic                cs_n,
    output logic                ps0_wake,
    output logic                initialized,
    output logic                error,
    output logic                delay_run,
    output bno_pkg::delay_sel_t delay_sel,
    input  logic                delay_done,
    output bno_pkg::step_t      cmd_step,
    output logic                cmd_clear,
    output logic                cmd_advance,
    input  bno_pkg::byte_t      cmd_byte,
    input  logic                cmd_last,
    output logic                pkt_clear,
    input  logic                hdr_done,
    input  logic                hdr_ok,
    input  logic                pkt_last
);
    import bno_pkg::*;

    seq_state_t state;
    step_t      step;
    logic       int_sync;
    logic       inflight;   // One SPI byte outstanding
    logic       can_issue;

    assign can_issue = !inflight && !spi_busy;

    always_comb begin
        case (state)
            ST_POWER_UP: delay_sel = DLY_POWER_UP;
            ST_WAKE:     delay_sel = DLY_WAKE;
            ST_WAIT_INT: delay_sel = DLY_INT_TIMEOUT;
            default:     delay_sel = DLY_GAP;
        endcase
    end

    // Dropping run on done restarts the timer for the next timed state
    assign delay_run = (state inside {ST_POWER_UP, ST_WAKE, ST_WAIT_INT, ST_GAP})
                       && !delay_done;

    assign cmd_step    = step;
    assign cmd_clear   = state == ST_CS_SETUP;
    assign cmd_advance = (state == ST_SEND_CMD) && spi_rx_valid;
    assign pkt_clear   = (state == ST_IDLE) && !int_sync;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_POWER_UP;
            step        <= '0;
            int_sync    <= 1'b1;
            inflight    <= 1'b0;
            spi_start   <= 1'b0;
            spi_tx_data <= '0;
            cs_n        <= 1'b1;
            ps0_wake    <= 1'b1;
            initialized <= 1'b0;
            error       <= 1'b0;
        end else begin
            int_sync  <= int_n;
            spi_start <= 1'b0;
            if (spi_rx_valid) inflight <= 1'b0;

            case (state)
                ST_POWER_UP: begin
                    cs_n     <= 1'b1;
                    ps0_wake <= 1'b1;
                    if (delay_done) begin
                        step     <= '0;
                        ps0_wake <= 1'b0;
                        state    <= ST_WAKE;
                    end
                end
                ST_WAKE: begin
                    if (delay_done) state <= ST_WAIT_INT;
                end
                ST_WAIT_INT: begin
                    if (!int_sync) begin
                        state <= ST_CS_SETUP;
                    end else if (delay_done) begin
                        error    <= 1'b1;  // Sticky until reset
                        ps0_wake <= 1'b1;
                        state    <= ST_POWER_UP;
                    end
                end
                ST_CS_SETUP: begin
                    cs_n     <= 1'b0;
                    ps0_wake <= 1'b1;
                    state    <= ST_SEND_CMD;
                end
                ST_SEND_CMD: begin
                    if (spi_rx_valid && cmd_last) begin
                        cs_n  <= 1'b1;
                        state <= ST_GAP;
                    end else if (can_issue) begin
                        spi_start   <= 1'b1;
                        spi_tx_data <= cmd_byte;
                        inflight    <= 1'b1;
                    end
                end
                ST_GAP: begin
                    if (delay_done) begin
                        if (step == step_t'(2)) begin
                            initialized <= 1'b1;
                            state       <= ST_IDLE;
                        end else begin
                            step     <= step + 1'b1;
                            ps0_wake <= 1'b0;
                            state    <= ST_WAKE;
                        end
                    end
                end
                ST_IDLE: begin
                    if (!int_sync) begin
                        cs_n  <= 1'b0;
                        state <= ST_READ_HDR;
                    end
                end
                ST_READ_HDR: begin
                    if (hdr_done) begin
                        if (hdr_ok) begin
                            state <= ST_READ_PAYLOAD;
                        end else begin
                            cs_n  <= 1'b1;
                            state <= ST_IDLE;
                        end
                    end else if (can_issue) begin
                        spi_start   <= 1'b1;
                        spi_tx_data <= '0;
                        inflight    <= 1'b1;
                    end
                end
                ST_READ_PAYLOAD: begin
                    if (pkt_last) begin
                        cs_n  <= 1'b1;
                        state <= ST_IDLE;
                    end else if (can_issue) begin
                        spi_start   <= 1'b1;
                        spi_tx_data <= '0;
                        inflight    <= 1'b1;
                    end
                end
                default: state <= ST_POWER_UP;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: list.f
bno_pkg.sv
bno_delay_timer.sv
shtp_cmd_rom.sv
shtp_packet_parser.sv
bno_sequencer.sv
bno085_controller.sv
bno085_sva.sv
tb_clkgen.sv
tb_bno085.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_bno085 -f list.f -o sim_bno085 &&
./obj_dir/sim_bno085 | tee /dev/stderr | grep -x "Test passed" > /dev/null &&
echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// File: shtp_cmd_rom.sv
`timescale 1ns/1ps
`default_nettype none

module shtp_cmd_rom (
    input  logic           clk,
    input  logic           rst_n,
    input  bno_pkg::step_t cmd_step,
    input  logic           cmd_clear,
    input  logic           cmd_advance,
    output bno_pkg::byte_t cmd_byte,
    output logic           cmd_last
);
    import bno_pkg::*;

    cmd_idx_t idx;
    cmd_idx_t cmd_len;
    byte_t    feature_id;

    // Product ID request is short and both Set Feature commands are 17 bytes
    assign cmd_len    = (cmd_step == step_t'(0)) ? cmd_idx_t'(5) : cmd_idx_t'(17);
    assign cmd_last   = idx == cmd_len - cmd_idx_t'(1);
    assign feature_id = (cmd_step == step_t'(1)) ? REPORT_ID_ROTATION_VECTOR
                                                 : REPORT_ID_GYROSCOPE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx <= '0;
        end else if (cmd_clear) begin
            idx <= '0;
        end else if (cmd_advance) begin
            idx <= idx + 1'b1;
        end
    end

    always_comb begin
        case (idx)
            5'd0:    cmd_byte = byte_t'(cmd_len);  // Length fits in the LSB
            5'd2:    cmd_byte = CHANNEL_CONTROL;
            5'd3:    cmd_byte = byte_t'(cmd_step);  // Sequence number
            5'd4: begin
                if (cmd_step == step_t'(0)) begin
                    cmd_byte = REPORT_ID_PRODUCT_ID_REQ;
                end else begin
                    cmd_byte = REPORT_ID_SET_FEATURE;
                end
            end
            5'd5:    cmd_byte = feature_id;
            // Flags and sensitivity at 6..8 stay zero
            5'd9:    cmd_byte = REPORT_INTERVAL_US[7:0];
            5'd10:   cmd_byte = REPORT_INTERVAL_US[15:8];
            5'd11:   cmd_byte = REPORT_INTERVAL_US[23:16];
            5'd12:   cmd_byte = REPORT_INTERVAL_US[31:24];
            default: cmd_byte = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: shtp_packet_parser.sv
`timescale 1ns/1ps
`default_nettype none

module shtp_packet_parser (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             pkt_clear,
    input  logic             spi_rx_valid,
    input  bno_pkg::byte_t   spi_rx_data,
    output logic             hdr_done,
    output logic             hdr_ok,
    output logic             pkt_last,
    output logic             quat_valid,
    output bno_pkg::sample_t quat_w,
    output bno_pkg::sample_t quat_x,
    output bno_pkg::sample_t quat_y,
    output bno_pkg::sample_t quat_z,
    output logic             gyro_valid,
    output bno_pkg::sample_t gyro_x,
    output bno_pkg::sample_t gyro_y,
    output bno_pkg::sample_t gyro_z
);
    import bno_pkg::*;

    logic       active;     // A packet read is in progress
    logic       hdr_phase;
    logic [1:0] hdr_cnt;
    pkt_len_t   pay_cnt;
    pkt_len_t   pkt_len;
    byte_t      len_lo;
    byte_t      channel;
    byte_t      report_id;
    byte_t      lsb;        // Low half of the field being assembled
    logic       pay_rx;
    logic       ch_ok;
    logic       is_rot;
    logic       is_gyro;

    assign hdr_done = active && hdr_phase && spi_rx_valid
                      && (hdr_cnt == 2'(SHTP_HDR_BYTES - 1));
    assign hdr_ok   = pkt_len > pkt_len_t'(SHTP_HDR_BYTES);
    assign pay_rx   = active && !hdr_phase && spi_rx_valid;
    // Final payload byte has index length - 5
    assign pkt_last = pay_rx && (pay_cnt == pkt_len - pkt_len_t'(SHTP_HDR_BYTES + 1));

    assign ch_ok   = (channel == CHANNEL_REPORTS) || (channel == CHANNEL_GYRO_RV);
    assign is_rot  = ch_ok && (report_id == REPORT_ID_ROTATION_VECTOR);
    assign is_gyro = ch_ok && (report_id == REPORT_ID_GYROSCOPE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            hdr_phase <= 1'b1;
            hdr_cnt   <= '0;
            pay_cnt   <= '0;
        end else if (pkt_clear) begin
            active    <= 1'b1;
            hdr_phase <= 1'b1;
            hdr_cnt   <= '0;
            pay_cnt   <= '0;
        end else if (hdr_done) begin
            hdr_phase <= 1'b0;
            active    <= hdr_ok;  // Empty packet ends here
        end else if (pkt_last) begin
            active <= 1'b0;
        end else if (active && spi_rx_valid) begin
            if (hdr_phase) begin
                hdr_cnt <= hdr_cnt + 1'b1;
            end else begin
                pay_cnt <= pay_cnt + 1'b1;
            end
        end
    end

    // Header and report ID capture
    always_ff @(posedge clk) begin
        if (active && hdr_phase && spi_rx_valid) begin
            case (hdr_cnt)
                2'd0:    len_lo  <= spi_rx_data;
                2'd1:    pkt_len <= {spi_rx_data[6:0], len_lo};  // Drop continuation bit
                2'd2:    channel <= spi_rx_data;
                default: ;                                        // Sequence number
            endcase
        end
        if (pay_rx) begin
            if (pay_cnt == '0) begin
                report_id <= spi_rx_data;
            end
            if (!pay_cnt[0]) begin
                lsb <= spi_rx_data;
            end
        end
    end

    // Fields are little-endian pairs from payload byte 4 on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quat_valid <= 1'b0;
            gyro_valid <= 1'b0;
            quat_w     <= '0;
            quat_x     <= '0;
            quat_y     <= '0;
            quat_z     <= '0;
            gyro_x     <= '0;
            gyro_y     <= '0;
            gyro_z     <= '0;
        end else begin
            quat_valid <= 1'b0;
            gyro_valid <= 1'b0;
            if (pay_rx) begin
                case (pay_cnt)
                    15'd5: begin
                        if (is_rot) quat_x <= {spi_rx_data, lsb};
                        if (is_gyro) gyro_x <= {spi_rx_data, lsb};
                    end
                    15'd7: begin
                        if (is_rot) quat_y <= {spi_rx_data, lsb};
                        if (is_gyro) gyro_y <= {spi_rx_data, lsb};
                    end
                    15'd9: begin
                        if (is_rot) quat_z <= {spi_rx_data, lsb};
                        if (is_gyro) gyro_z <= {spi_rx_data, lsb};
                        gyro_valid <= is_gyro;  // Gyro report is complete
                    end
                    15'd11: begin
                        if (is_rot) quat_w <= {spi_rx_data, lsb};
                        quat_valid <= is_rot;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_bno085.sv
`timescale 1ns/1ps
`default_nettype none

bind bno085_controller bno085_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .spi_start  (spi_start),
    .spi_busy   (spi_busy),
    .cs_n       (cs_n),
    .quat_valid (quat_valid),
    .gyro_valid (gyro_valid),
    .error      (error)
);

module tb_bno085;
    localparam int RESET_CYC  = 20;
    localparam int WAKE_CYC   = 5;
    localparam int INT_TO_CYC = 40;
    localparam int GAP_CYC    = 10;
    localparam int BYTE_CYC   = 8;   // Start, 3 busy cycles and margin
    localparam int INIT_CYC   = RESET_CYC + 3 * (WAKE_CYC + INT_TO_CYC + GAP_CYC + 17 * BYTE_CYC);
    localparam int PKT_CYC    = 20 * BYTE_CYC;
    localparam int ERR_CYC    = 2 * (RESET_CYC + WAKE_CYC + INT_TO_CYC);
    localparam int LIMIT      = 2 * (INIT_CYC + 6 * PKT_CYC + ERR_CYC) + 100;

    logic clk;
    logic rst_n;
    logic reset_req = 1'b0;
    logic sensor_en = 1'b1;
    logic spi_start;
    logic [7:0] spi_tx_data;
    logic spi_busy = 1'b0;
    logic spi_rx_valid = 1'b0;
    logic [7:0] spi_rx_data = 8'h00;
    logic cs_n;
    logic ps0_wake;
    logic int_n = 1'b1;
    logic quat_valid;
    logic gyro_valid;
    logic signed [15:0] quat_w, quat_x, quat_y, quat_z;
    logic signed [15:0] gyro_x, gyro_y, gyro_z;
    logic initialized;
    logic error;

    int errors = 0;
    int checks = 0;
    int cycle = 0;
    int last_cs_rise = 0;
    int quat_pulses = 0;
    int gyro_pulses = 0;
    int pkt_req = 0;
    int served = 0;
    int ptr = 0;
    int busy_cnt = 0;
    int seq_no = 0;
    logic cs_q = 1'b1;
    logic [7:0] rx_hold = 8'h00;
    logic [15:0] lfsr;
    logic [7:0] pkt_q[$];    // Bytes the sensor returns on the next read
    logic [7:0] pay_q[$];
    logic [15:0] fld_q[$];
    logic [7:0] init_tx[$];  // Bytes sent before initialized

    tb_clkgen #(.PERIOD_NS(10), .POR_CYCLES(2)) u_clk (
        .clk       (clk),
        .rst_n     (rst_n),
        .reset_req (reset_req)
    );

    bno085_controller #(
        .RESET_CYCLES       (RESET_CYC),
        .WAKE_CYCLES        (WAKE_CYC),
        .INT_TIMEOUT_CYCLES (INT_TO_CYC),
        .GAP_CYCLES         (GAP_CYC)
    ) uut (
        .clk(clk), .rst_n(rst_n), .spi_start(spi_start), .spi_tx_data(spi_tx_data),
        .spi_busy(spi_busy), .spi_rx_valid(spi_rx_valid), .spi_rx_data(spi_rx_data),
        .cs_n(cs_n), .ps0_wake(ps0_wake), .int_n(int_n),
        .quat_valid(quat_valid), .quat_w(quat_w), .quat_x(quat_x), .quat_y(quat_y),
        .quat_z(quat_z), .gyro_valid(gyro_valid), .gyro_x(gyro_x), .gyro_y(gyro_y),
        .gyro_z(gyro_z), .initialized(initialized), .error(error)
    );

    // SPI master with sensor data and 3 busy cycles per byte
    always @(posedge clk) begin
        if (!rst_n) begin
            spi_busy     <= 1'b0;
            spi_rx_valid <= 1'b0;
            busy_cnt     <= 0;
        end else begin
            spi_rx_valid <= 1'b0;
            if (cs_n) ptr <= 0;
            if (spi_start) begin
                spi_busy <= 1'b1;
                busy_cnt <= 3;
                if (!initialized) init_tx.push_back(spi_tx_data);
                if (!cs_n && ptr < pkt_q.size()) begin
                    rx_hold <= pkt_q[ptr];
                    ptr     <= ptr + 1;
                end else begin
                    rx_hold <= 8'h00;
                end
            end else if (spi_busy) begin
                if (busy_cnt == 1) begin
                    spi_busy     <= 1'b0;
                    spi_rx_valid <= 1'b1;
                    spi_rx_data  <= rx_hold;
                end
                busy_cnt <= busy_cnt - 1;
            end
        end
    end

    // Interrupt on a wake or a queued packet until chip select falls
    always @(posedge clk) begin
        if (!rst_n) begin
            int_n <= 1'b1;
        end else if (!cs_n) begin
            int_n <= 1'b1;
            if (cs_q && pkt_req != served) served <= served + 1;
        end else if (sensor_en && (!ps0_wake || pkt_req != served)) begin
            int_n <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        cs_q  <= cs_n;
        if (!cs_q && cs_n) last_cs_rise <= cycle;
        if (quat_valid) quat_pulses <= quat_pulses + 1;
        if (gyro_valid) gyro_pulses <= gyro_pulses + 1;
        if (cycle >= LIMIT) begin
            $display("ERROR: run did not finish within %0d cycles", LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    // Command table as the sensor expects it
    function automatic logic [7:0] cmd_expected(input int step, input int idx);
        logic [31:0] ivl;
        ivl = 32'd20000;
        case (idx)
            0:       return (step == 0) ? 8'd5 : 8'd17;
            2:       return 8'h02;
            3:       return 8'(step);
            4:       return (step == 0) ? 8'hF9 : 8'hFD;
            5:       return (step == 1) ? 8'h05 : 8'h02;
            9:       return ivl[7:0];
            10:      return ivl[15:8];
            11:      return ivl[23:16];
            12:      return ivl[31:24];
            default: return 8'h00;
        endcase
    endfunction

    function automatic logic [111:0] out_snapshot();
        return {quat_w, quat_x, quat_y, quat_z, gyro_x, gyro_y, gyro_z};
    endfunction

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        checks++;
        assert (exp === act) else begin
            $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        checks++;
        assert (cond === 1'b1) else begin
            $display("ERROR: %s", what);
            errors++;
        end
    endtask

    task automatic rand16(output logic [15:0] v);
        v = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    // Report ID, sequence, status, delay, then 16-bit fields
    task automatic build_report(input logic [7:0] id, input int nfields);
        logic [15:0] v;
        pay_q.delete();
        fld_q.delete();
        pay_q.push_back(id);
        pay_q.push_back(8'h01);
        pay_q.push_back(8'h03);
        pay_q.push_back(8'h00);
        for (int i = 0; i < nfields; i++) begin
            rand16(v);
            fld_q.push_back(v);
            pay_q.push_back(v[7:0]);
            pay_q.push_back(v[15:8]);
        end
    endtask

    task automatic wait_cs(input logic level, input string what);
        int n;
        n = 0;
        while (cs_n !== level && n < LIMIT) begin
            @(posedge clk);
            n++;
        end
        check_true(what, cs_n === level);
    endtask

    task automatic send_packet(input logic [7:0] ch, input logic with_payload);
        int total;
        total = 4 + (with_payload ? pay_q.size() : 0);
        pkt_q.delete();
        pkt_q.push_back(total[7:0]);
        pkt_q.push_back(total[15:8]);
        pkt_q.push_back(ch);
        pkt_q.push_back(seq_no[7:0]);
        seq_no++;
        if (with_payload) begin
            foreach (pay_q[i]) pkt_q.push_back(pay_q[i]);
        end
        @(posedge clk);
        pkt_req <= pkt_req + 1;
        wait_cs(1'b0, "chip select did not fall for a packet read");
        wait_cs(1'b1, "chip select did not return high after a packet");
        repeat (3) @(posedge clk);
    endtask

    initial begin
        int n;
        int k;
        int q0;
        int g0;
        logic [111:0] snap;
        lfsr = 16'd44329;
        @(posedge clk);
        n = 0;
        while (!initialized && n < LIMIT) begin
            @(posedge clk);
            n++;
        end
        check_true("initialized never rose", initialized);
        check_value("init_count", 128'(39), 128'(init_tx.size()));
        k = 0;
        for (int s = 0; s < 3; s++) begin
            for (int i = 0; i < ((s == 0) ? 5 : 17); i++) begin
                if (k < init_tx.size()) begin
                    check_value("init_cmd", 128'(cmd_expected(s, i)), 128'(init_tx[k]));
                end
                k++;
            end
        end
        check_true("initialized rose before the last gap", cycle - last_cs_rise >= GAP_CYC - 2);

        // Gyroscope on channel 3
        q0 = quat_pulses;
        g0 = gyro_pulses;
        build_report(8'h02, 3);
        send_packet(8'h03, 1'b1);
        check_value("gyro_x", 128'(fld_q[0]), 128'($unsigned(gyro_x)));
        check_value("gyro_y", 128'(fld_q[1]), 128'($unsigned(gyro_y)));
        check_value("gyro_z", 128'(fld_q[2]), 128'($unsigned(gyro_z)));
        check_value("gyro_pulses", 128'(1), 128'(gyro_pulses - g0));
        check_value("gyro_no_quat", 128'(0), 128'(quat_pulses - q0));

        // Rotation Vector on channel 5
        q0 = quat_pulses;
        build_report(8'h05, 4);
        send_packet(8'h05, 1'b1);
        check_value("quat_x", 128'(fld_q[0]), 128'($unsigned(quat_x)));
        check_value("quat_y", 128'(fld_q[1]), 128'($unsigned(quat_y)));
        check_value("quat_z", 128'(fld_q[2]), 128'($unsigned(quat_z)));
        check_value("quat_w", 128'(fld_q[3]), 128'($unsigned(quat_w)));
        check_value("quat_pulses", 128'(1), 128'(quat_pulses - q0));

        // Control channel and empty header are ignored
        snap = out_snapshot();
        q0   = quat_pulses;
        g0   = gyro_pulses;
        build_report(8'h05, 4);
        send_packet(8'h02, 1'b1);
        check_value("ch2_outputs", 128'(snap), 128'(out_snapshot()));
        send_packet(8'h03, 1'b0);
        check_value("len4_outputs", 128'(snap), 128'(out_snapshot()));
        check_value("ignored_pulses", 128'(0), 128'(quat_pulses - q0 + gyro_pulses - g0));
        check_value("ignored_cs_n", 128'(1), 128'(cs_n));
        build_report(8'h02, 3);
        send_packet(8'h03, 1'b1);
        check_value("gyro_again_x", 128'(fld_q[0]), 128'($unsigned(gyro_x)));
        check_value("gyro_again_z", 128'(fld_q[2]), 128'($unsigned(gyro_z)));

        // Second run with a silent sensor
        @(posedge clk);
        sensor_en <= 1'b0;
        reset_req <= 1'b1;
        repeat (2) @(posedge clk);
        reset_req <= 1'b0;
        n = 0;
        while (!error && n < ERR_CYC) begin
            @(posedge clk);
            n++;
        end
        check_true("error did not rise on interrupt timeout", error);
        check_true("wake was not released after the timeout", ps0_wake);
        n = 0;
        while (ps0_wake && n < ERR_CYC) begin
            @(posedge clk);
            n++;
        end
        check_true("wake was not repeated after the timeout", !ps0_wake);
        check_true("error did not stay high", error);
        check_true("initialized rose without a sensor", !initialized);

        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, uut.u_sva.fail_count);
        if (errors == 0 && uut.u_sva.fail_count == 0 && checks > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS  = 10,
    parameter int POR_CYCLES = 2
) (
    output logic clk,
    output logic rst_n,
    input  logic reset_req   // Extra reset pulse from the testbench
);
    logic por_done;

    initial begin
        clk      = 1'b0;
        por_done = 1'b0;
        repeat (POR_CYCLES) @(posedge clk);
        por_done <= 1'b1;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

    assign rst_n = por_done && !reset_req;

endmodule

`default_nettype wire
